// ==== filelist.f ====
source/io_pkg.sv
source/byte_channel.sv
source/user_io.sv
source/core_regs.sv
source/io_subsystem.sv
verif/tb_io_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
   --top-module tb_io_subsystem -f filelist.f

out=$(./obj_dir/Vtb_io_subsystem)
echo "$out"

# the run passes only if the testbench printed its pass line
echo "$out" | grep -q '^\*\* PASS \*\*$'

// ==== source/byte_channel.sv ====
`timescale 1ns/1ns
`default_nettype none

module byte_channel #(
   parameter int depth = 4
) (
   input  wire        SPI_CLK,
   input  wire        flush,

   // inbound side, filled from spi
   input  wire        rx_push,
   input  wire  [7:0] rx_byte,

   // core side
   input  wire        core_rd,
   input  wire        core_wr,
   input  wire  [7:0] core_wdata,
   output logic [7:0] core_rdata,
   output logic       rx_valid,
   output logic       tx_full,
   output logic       overflow,

   // outbound side, drained over spi
   input  wire        tx_pop,
   output logic       tx_avail,
   output logic [7:0] tx_head
);

   localparam int aw = $clog2(depth);

   // queue 0 runs towards the core, queue 1 towards the io controller
   logic [7:0]  mem  [2][depth];
   logic [aw:0] wp   [2];
   logic [aw:0] rp   [2];
   logic [7:0]  din  [2];
   logic [7:0]  head [2];
   logic [1:0]  push;
   logic [1:0]  pop;
   logic [1:0]  empty;
   logic [1:0]  full;

   assign push    = {core_wr, rx_push};
   assign pop     = {tx_pop, core_rd};
   assign din[0]  = rx_byte;
   assign din[1]  = core_wdata;

   for (genvar q = 0; q < 2; q++) begin : g_queue
      // extra pointer bit tells full from empty
      assign empty[q] = (wp[q] == rp[q]);
      assign full[q]  = (wp[q][aw] != rp[q][aw]) && (wp[q][aw-1:0] == rp[q][aw-1:0]);
      assign head[q]  = mem[q][rp[q][aw-1:0]];
   end

   always_ff @(posedge SPI_CLK) begin
      for (int q = 0; q < 2; q++) begin
         if (push[q] && !full[q] && !flush) begin
            mem[q][wp[q][aw-1:0]] <= din[q];
         end
      end
   end

   always_ff @(posedge SPI_CLK) begin
      if (flush) begin
         for (int q = 0; q < 2; q++) begin
            wp[q] <= '0;
            rp[q] <= '0;
         end
         overflow <= 1'b0;
      end else begin
         for (int q = 0; q < 2; q++) begin
            if (push[q] && !full[q]) begin
               wp[q] <= wp[q] + 1'b1;
            end
            // popping an empty queue does nothing
            if (pop[q] && !empty[q]) begin
               rp[q] <= rp[q] + 1'b1;
            end
         end
         // sticky until the next flush
         if (|(push & full)) begin
            overflow <= 1'b1;
         end
      end
   end

   assign core_rdata = empty[0] ? 8'h00 : head[0];
   assign rx_valid   = !empty[0];
   assign tx_full    = full[1];
   assign tx_avail   = !empty[1];
   assign tx_head    = head[1];

endmodule

`default_nettype wire

// ==== source/core_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_regs #(
   parameter int num_chan = io_pkg::NUM_CHAN
) (
   input  wire                       SPI_CLK,
   input  wire                       SPI_SS_IO,

   // AXI4-Lite write channels
   input  wire  [7:0]                s_axi_awaddr,
   input  wire                       s_axi_awvalid,
   output logic                      s_axi_awready,
   input  wire  [31:0]               s_axi_wdata,
   input  wire                       s_axi_wvalid,
   output logic                      s_axi_wready,
   output logic [1:0]                s_axi_bresp,
   output logic                      s_axi_bvalid,
   input  wire                       s_axi_bready,

   // AXI4-Lite read channels
   input  wire  [7:0]                s_axi_araddr,
   input  wire                       s_axi_arvalid,
   output logic                      s_axi_arready,
   output logic [31:0]               s_axi_rdata,
   output logic [1:0]                s_axi_rresp,
   output logic                      s_axi_rvalid,
   input  wire                       s_axi_rready,

   // channel access
   output logic [num_chan-1:0]       core_rd,
   output logic [num_chan-1:0]       core_wr,
   output logic [7:0]                core_wdata,
   input  wire  [num_chan-1:0][7:0]  core_rdata,
   input  wire  [num_chan-1:0]       rx_valid,
   input  wire  [num_chan-1:0]       tx_full,
   input  wire  [num_chan-1:0]       overflow
);

   import io_pkg::*;

   logic        wr_go;
   logic        rd_go;
   logic [4:0]  wr_ch;
   logic [4:0]  rd_ch;
   logic [2:0]  wr_off;
   logic [2:0]  rd_off;
   logic        wr_hit;
   logic        rd_hit;
   logic [31:0] rd_word;

   // accept only while no response of the same kind is waiting
   assign wr_go = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
   assign rd_go = s_axi_arvalid && !s_axi_rvalid;

   assign s_axi_awready = wr_go;
   assign s_axi_wready  = wr_go;
   assign s_axi_arready = rd_go;

   // address is channel * 8 + offset
   assign wr_ch  = s_axi_awaddr[7:3];
   assign wr_off = s_axi_awaddr[2:0];
   assign rd_ch  = s_axi_araddr[7:3];
   assign rd_off = s_axi_araddr[2:0];

   assign wr_hit = (int'(wr_ch) < num_chan) && ((wr_off == REG_DATA) || (wr_off == REG_STATUS));
   assign rd_hit = (int'(rd_ch) < num_chan) && ((rd_off == REG_DATA) || (rd_off == REG_STATUS));

   assign core_wdata = s_axi_wdata[7:0];

   // data register accesses push or pop in the handshake cycle
   always_comb begin
      for (int i = 0; i < num_chan; i++) begin
         core_wr[i] = wr_go && wr_hit && (wr_off == REG_DATA) && (int'(wr_ch) == i);
         core_rd[i] = rd_go && rd_hit && (rd_off == REG_DATA) && (int'(rd_ch) == i);
      end
   end

   always_comb begin
      rd_word = '0;
      for (int i = 0; i < num_chan; i++) begin
         if (rd_hit && (int'(rd_ch) == i)) begin
            if (rd_off == REG_DATA) begin
               rd_word[7:0] = core_rdata[i];
            end else begin
               rd_word[ST_RX_VALID] = rx_valid[i];
               rd_word[ST_TX_FULL]  = tx_full[i];
               rd_word[ST_OVERFLOW] = overflow[i];
            end
         end
      end
   end

   // response payload only changes on a new handshake
   always_ff @(posedge SPI_CLK) begin
      if (wr_go) begin
         s_axi_bresp <= wr_hit ? AXI_OKAY : AXI_SLVERR;
      end
      if (rd_go) begin
         s_axi_rdata <= rd_word;
         s_axi_rresp <= rd_hit ? AXI_OKAY : AXI_SLVERR;
      end
   end

   always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
      if (SPI_SS_IO) begin
         s_axi_bvalid <= 1'b0;
         s_axi_rvalid <= 1'b0;
      end else begin
         if (wr_go) begin
            s_axi_bvalid <= 1'b1;
         end else if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
         end
         if (rd_go) begin
            s_axi_rvalid <= 1'b1;
         end else if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/io_pkg.sv ====
`default_nettype none

package io_pkg;

   // channel 0 is the keyboard link, channel 1 the serial link
   localparam int NUM_CHAN = 2;

   // command bytes sent by the io controller
   localparam logic [7:0] CMD_BUT_SW = 8'd1;
   localparam logic [7:0] CMD_KBD_WR = 8'd2;
   localparam logic [7:0] CMD_KBD_RD = 8'd3;
   localparam logic [7:0] CMD_SER_WR = 8'd4;
   localparam logic [7:0] CMD_SER_RD = 8'd5;
   localparam logic [7:0] CMD_FLUSH  = 8'd6;

   // register offsets inside the 8-byte window of each channel
   localparam logic [2:0] REG_DATA   = 3'd0;
   localparam logic [2:0] REG_STATUS = 3'd4;

   // bit positions in the status word
   localparam int ST_RX_VALID = 0;
   localparam int ST_TX_FULL  = 1;
   localparam int ST_OVERFLOW = 2;

   // AXI response codes
   localparam logic [1:0] AXI_OKAY   = 2'b00;
   localparam logic [1:0] AXI_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== source/io_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module io_subsystem #(
   parameter int         num_chan  = io_pkg::NUM_CHAN,
   parameter int         depth     = 4,
   parameter logic [7:0] core_type = 8'hA5
) (
   input  wire         SPI_CLK,
   input  wire         SPI_SS_IO,
   input  wire         spi_mosi,
   output logic        spi_miso,

   input  wire  [7:0]  s_axi_awaddr,
   input  wire         s_axi_awvalid,
   output logic        s_axi_awready,
   input  wire  [31:0] s_axi_wdata,
   input  wire         s_axi_wvalid,
   output logic        s_axi_wready,
   output logic [1:0]  s_axi_bresp,
   output logic        s_axi_bvalid,
   input  wire         s_axi_bready,
   input  wire  [7:0]  s_axi_araddr,
   input  wire         s_axi_arvalid,
   output logic        s_axi_arready,
   output logic [31:0] s_axi_rdata,
   output logic [1:0]  s_axi_rresp,
   output logic        s_axi_rvalid,
   input  wire         s_axi_rready,

   output logic [1:0]  buttons,
   output logic [1:0]  switches
);

   logic [num_chan-1:0]      rx_push;
   logic [num_chan-1:0]      tx_pop;
   logic [num_chan-1:0]      tx_avail;
   logic [num_chan-1:0][7:0] tx_head;
   logic [7:0]               rx_byte;
   logic                     flush;
   logic [num_chan-1:0]      core_rd;
   logic [num_chan-1:0]      core_wr;
   logic [7:0]               core_wdata;
   logic [num_chan-1:0][7:0] core_rdata;
   logic [num_chan-1:0]      rx_valid;
   logic [num_chan-1:0]      tx_full;
   logic [num_chan-1:0]      overflow;

   user_io #(
      .num_chan  (num_chan),
      .core_type (core_type)
   ) u_user_io (
      .SPI_CLK   (SPI_CLK),
      .SPI_SS_IO (SPI_SS_IO),
      .spi_mosi  (spi_mosi),
      .spi_miso  (spi_miso),
      .rx_push   (rx_push),
      .rx_byte   (rx_byte),
      .tx_pop    (tx_pop),
      .flush     (flush),
      .buttons   (buttons),
      .switches  (switches),
      .tx_avail  (tx_avail),
      .tx_head   (tx_head)
   );

   for (genvar n = 0; n < num_chan; n++) begin : g_chan
      byte_channel #(
         .depth (depth)
      ) u_chan (
         .SPI_CLK    (SPI_CLK),
         .flush      (flush),
         .rx_push    (rx_push[n]),
         .rx_byte    (rx_byte),
         .core_rd    (core_rd[n]),
         .core_wr    (core_wr[n]),
         .core_wdata (core_wdata),
         .core_rdata (core_rdata[n]),
         .rx_valid   (rx_valid[n]),
         .tx_full    (tx_full[n]),
         .overflow   (overflow[n]),
         .tx_pop     (tx_pop[n]),
         .tx_avail   (tx_avail[n]),
         .tx_head    (tx_head[n])
      );
   end

   core_regs #(
      .num_chan (num_chan)
   ) u_core_regs (
      .SPI_CLK       (SPI_CLK),
      .SPI_SS_IO     (SPI_SS_IO),
      .s_axi_awaddr  (s_axi_awaddr),
      .s_axi_awvalid (s_axi_awvalid),
      .s_axi_awready (s_axi_awready),
      .s_axi_wdata   (s_axi_wdata),
      .s_axi_wvalid  (s_axi_wvalid),
      .s_axi_wready  (s_axi_wready),
      .s_axi_bresp   (s_axi_bresp),
      .s_axi_bvalid  (s_axi_bvalid),
      .s_axi_bready  (s_axi_bready),
      .s_axi_araddr  (s_axi_araddr),
      .s_axi_arvalid (s_axi_arvalid),
      .s_axi_arready (s_axi_arready),
      .s_axi_rdata   (s_axi_rdata),
      .s_axi_rresp   (s_axi_rresp),
      .s_axi_rvalid  (s_axi_rvalid),
      .s_axi_rready  (s_axi_rready),
      .core_rd       (core_rd),
      .core_wr       (core_wr),
      .core_wdata    (core_wdata),
      .core_rdata    (core_rdata),
      .rx_valid      (rx_valid),
      .tx_full       (tx_full),
      .overflow      (overflow)
   );

endmodule

`default_nettype wire

// ==== source/user_io.sv ====
`timescale 1ns/1ns
`default_nettype none

module user_io #(
   parameter int         num_chan  = io_pkg::NUM_CHAN,
   parameter logic [7:0] core_type = 8'hA5
) (
   input  wire                          SPI_CLK,
   input  wire                          SPI_SS_IO,
   input  wire                          spi_mosi,
   output logic                         spi_miso,

   // towards the channels
   output logic [num_chan-1:0]          rx_push,
   output logic [7:0]                   rx_byte,
   output logic [num_chan-1:0]          tx_pop,
   output logic                         flush,

   output logic [1:0]                   buttons,
   output logic [1:0]                   switches,

   // outbound queue heads
   input  wire  [num_chan-1:0]          tx_avail,
   input  wire  [num_chan-1:0][7:0]     tx_head
);

   import io_pkg::*;

   logic [3:0] cnt;
   logic       toggle;
   logic [6:0] sbuf;
   logic [7:0] cmd;
   logic [3:0] but_sw;
   logic [7:0] shift_byte;
   logic [2:0] bit_idx;
   logic       ser_sel;
   logic       wr_cmd;
   logic       rd_cmd;

   // byte completed by the bit on mosi right now
   assign shift_byte = {sbuf, spi_mosi};

   // msb first, both in the command byte (7-cnt) and in payload bytes (15-cnt)
   assign bit_idx = ~cnt[2:0];

   assign buttons  = but_sw[1:0];
   assign switches = but_sw[3:2];

   // keyboard commands go to channel 0, serial commands to channel 1
   assign ser_sel = (cmd == CMD_SER_WR) || (cmd == CMD_SER_RD);
   assign wr_cmd  = (cmd == CMD_KBD_WR) || (cmd == CMD_SER_WR);
   assign rd_cmd  = (cmd == CMD_KBD_RD) || (cmd == CMD_SER_RD);

   // shift register, command byte and payload holding registers
   always_ff @(posedge SPI_CLK) begin
      sbuf <= shift_byte[6:0];
      if (cnt == 4'd7) begin
         cmd <= shift_byte;
      end
      if (cnt == 4'd15) begin
         if (cmd == CMD_BUT_SW) begin
            but_sw <= shift_byte[3:0];
         end
         if (wr_cmd) begin
            rx_byte <= shift_byte;
         end
      end
   end

   // frame counter and strobes
   always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
      if (SPI_SS_IO) begin
         cnt     <= 4'd0;
         toggle  <= 1'b0;
         flush   <= 1'b0;
         rx_push <= '0;
         tx_pop  <= '0;
      end else begin
         // 0..7 for the command, then 8..15 for every payload byte
         if (cnt != 4'd15) begin
            cnt <= cnt + 4'd1;
         end else begin
            cnt    <= 4'd8;
            toggle <= !toggle;
         end

         flush <= (cnt == 4'd7) && (shift_byte == CMD_FLUSH);

         for (int i = 0; i < num_chan; i++) begin
            rx_push[i] <= (cnt == 4'd15) && wr_cmd && (i == int'(ser_sel));
            // pop lands on the edge that ends the data byte, so the next
            // available byte already sees the updated queue
            tx_pop[i]  <= (cnt == 4'd14) && toggle && rd_cmd && (i == int'(ser_sel));
         end
      end
   end

   // miso changes on the falling edge, half a bit ahead of the sampling edge
   always_ff @(negedge SPI_CLK) begin
      if (cnt <= 4'd7) begin
         spi_miso <= core_type[bit_idx];
      end else if (!rd_cmd) begin
         spi_miso <= 1'b0;
      end else if (!toggle) begin
         // every bit of the available byte, giving 0xff or 0x00
         spi_miso <= tx_avail[ser_sel];
      end else begin
         spi_miso <= tx_head[ser_sel][bit_idx];
      end
   end

endmodule

`default_nettype wire

// ==== verif/tb_io_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_io_subsystem;

   import io_pkg::*;

   localparam int         NCH       = 2;
   localparam int         DEPTH     = 4;
   localparam logic [7:0] CORE_TYPE = 8'hA5;

   localparam logic [7:0] OP_FLUSH  = 8'd0;
   localparam logic [7:0] OP_BUTSW  = 8'd1;
   localparam logic [7:0] OP_SPI_WR = 8'd2;
   localparam logic [7:0] OP_SPI_RD = 8'd3;
   localparam logic [7:0] OP_AXI_WR = 8'd4;
   localparam logic [7:0] OP_AXI_RD = 8'd5;
   localparam logic [7:0] OP_STATUS = 8'd6;
   localparam logic [7:0] OP_BAD_WR = 8'd7;
   localparam logic [7:0] OP_BAD_RD = 8'd8;

   localparam logic [7:0] S_RX  = 8'(1 << ST_RX_VALID);
   localparam logic [7:0] S_TX  = 8'(1 << ST_TX_FULL);
   localparam logic [7:0] S_OVF = 8'(1 << ST_OVERFLOW);

   localparam int NROWS = 34;
   localparam int LIMIT = NROWS * 60 + 200;

   // op, channel, count or address or rready hold, expected status
   localparam logic [31:0] STIM [NROWS] = '{
      {OP_FLUSH,  8'd0, 8'd0,  8'h00}, {OP_STATUS, 8'd0, 8'd0,  8'h00},
      {OP_BUTSW,  8'd0, 8'h0D, 8'h00}, {OP_BUTSW,  8'd0, 8'h06, 8'h00},
      {OP_SPI_WR, 8'd0, 8'd3,  8'h00}, {OP_STATUS, 8'd0, 8'd0,  S_RX},
      {OP_AXI_RD, 8'd0, 8'd3,  8'h00}, {OP_STATUS, 8'd0, 8'd0,  8'h00},
      {OP_AXI_RD, 8'd0, 8'd1,  8'h00}, {OP_SPI_WR, 8'd1, 8'd2,  8'h00},
      {OP_AXI_RD, 8'd1, 8'd2,  8'h00}, {OP_AXI_WR, 8'd0, 8'd2,  8'h00},
      {OP_SPI_RD, 8'd0, 8'd3,  8'h00}, {OP_AXI_WR, 8'd1, 8'd1,  8'h00},
      {OP_SPI_RD, 8'd1, 8'd2,  8'h00}, {OP_SPI_WR, 8'd0, 8'd5,  8'h00},
      {OP_STATUS, 8'd0, 8'd0,  S_RX | S_OVF},
      {OP_AXI_WR, 8'd1, 8'd5,  8'h00},
      {OP_STATUS, 8'd1, 8'd0,  S_TX | S_OVF},
      {OP_AXI_RD, 8'd0, 8'd4,  8'h00}, {OP_STATUS, 8'd0, 8'd3,  S_OVF},
      {OP_SPI_RD, 8'd1, 8'd2,  8'h00}, {OP_SPI_WR, 8'd0, 8'd2,  8'h00},
      {OP_AXI_WR, 8'd1, 8'd2,  8'h00}, {OP_STATUS, 8'd1, 8'd0,  S_TX | S_OVF},
      {OP_FLUSH,  8'd0, 8'd0,  8'h00},
      {OP_STATUS, 8'd0, 8'd0,  8'h00}, {OP_STATUS, 8'd1, 8'd0,  8'h00},
      {OP_SPI_RD, 8'd1, 8'd1,  8'h00}, {OP_BAD_WR, 8'd0, 8'h02, 8'h00},
      {OP_BAD_WR, 8'd0, 8'h10, 8'h00}, {OP_BAD_RD, 8'd0, 8'h0D, 8'h00},
      {OP_BAD_RD, 8'd0, 8'h14, 8'h00}, {OP_AXI_RD, 8'd1, 8'd1,  8'h00}
   };

   logic        SPI_CLK;
   logic        SPI_SS_IO;
   logic        spi_mosi;
   logic        spi_miso;
   logic [7:0]  s_axi_awaddr;
   logic        s_axi_awvalid;
   logic        s_axi_awready;
   logic [31:0] s_axi_wdata;
   logic        s_axi_wvalid;
   logic        s_axi_wready;
   logic [1:0]  s_axi_bresp;
   logic        s_axi_bvalid;
   logic        s_axi_bready;
   logic [7:0]  s_axi_araddr;
   logic        s_axi_arvalid;
   logic        s_axi_arready;
   logic [31:0] s_axi_rdata;
   logic [1:0]  s_axi_rresp;
   logic        s_axi_rvalid;
   logic        s_axi_rready;
   logic [1:0]  buttons;
   logic [1:0]  switches;

   int          cycles = 0;
   int          checks = 0;
   int          errors = 0;
   logic [31:0] lfsr = 32'h0287_26a9;
   logic [7:0]  mosi_buf [16];
   logic [7:0]  miso_buf [16];
   // expected inbound and outbound queue contents per channel
   logic [7:0]  rx_q [NCH][$];
   logic [7:0]  tx_q [NCH][$];

   io_subsystem #(
      .num_chan  (NCH),
      .depth     (DEPTH),
      .core_type (CORE_TYPE)
   ) dut0 (
      .SPI_CLK       (SPI_CLK),
      .SPI_SS_IO     (SPI_SS_IO),
      .spi_mosi      (spi_mosi),
      .spi_miso      (spi_miso),
      .s_axi_awaddr  (s_axi_awaddr),
      .s_axi_awvalid (s_axi_awvalid),
      .s_axi_awready (s_axi_awready),
      .s_axi_wdata   (s_axi_wdata),
      .s_axi_wvalid  (s_axi_wvalid),
      .s_axi_wready  (s_axi_wready),
      .s_axi_bresp   (s_axi_bresp),
      .s_axi_bvalid  (s_axi_bvalid),
      .s_axi_bready  (s_axi_bready),
      .s_axi_araddr  (s_axi_araddr),
      .s_axi_arvalid (s_axi_arvalid),
      .s_axi_arready (s_axi_arready),
      .s_axi_rdata   (s_axi_rdata),
      .s_axi_rresp   (s_axi_rresp),
      .s_axi_rvalid  (s_axi_rvalid),
      .s_axi_rready  (s_axi_rready),
      .buttons       (buttons),
      .switches      (switches)
   );

   initial begin
      SPI_CLK = 1'b0;
      forever #4 SPI_CLK = !SPI_CLK;
   end

   always @(posedge SPI_CLK) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("timeout: the test sequence did not finish within %0d cycles", LIMIT);
         $display("** FAIL **");
         $finish;
      end
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic random_byte(output logic [7:0] value);
      for (int i = 0; i < 8; i++) begin
         lfsr = lfsr_next(lfsr);
         value[i] = lfsr[0];
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
      end
   endtask

   // select high for 2 cycles clears the frame counter
   task automatic select_pulse();
      SPI_SS_IO = 1'b1;
      repeat (2) @(posedge SPI_CLK);
      #1 SPI_SS_IO = 1'b0;
   endtask

   task automatic spi_frame(input logic [7:0] cmd, input int nbytes);
      logic [7:0] out_byte;
      select_pulse();
      for (int b = 0; b <= nbytes; b++) begin
         out_byte = (b == 0) ? cmd : mosi_buf[b - 1];
         for (int k = 7; k >= 0; k--) begin
            spi_mosi = out_byte[k];
            @(posedge SPI_CLK);
            miso_buf[b][k] = spi_miso;
            #1;
         end
      end
      spi_mosi = 1'b0;
      // one more clock so the strobes of the last byte reach the channels
      @(posedge SPI_CLK);
      #1;
      // park the decoder on an idle command until the next frame
      select_pulse();
      check_value("spi_miso core type", miso_buf[0], CORE_TYPE);
   endtask

   task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      s_axi_awaddr  = addr;
      s_axi_wdata   = data;
      s_axi_awvalid = 1'b1;
      s_axi_wvalid  = 1'b1;
      @(negedge SPI_CLK);
      while (!s_axi_awready) @(negedge SPI_CLK);
      check_value("s_axi_wready", s_axi_wready, 1'b1);
      @(posedge SPI_CLK);
      #1;
      s_axi_awvalid = 1'b0;
      s_axi_wvalid  = 1'b0;
      @(negedge SPI_CLK);
      while (!s_axi_bvalid) @(negedge SPI_CLK);
      resp = s_axi_bresp;
      @(posedge SPI_CLK);
      #1 s_axi_bready = 1'b1;
      @(posedge SPI_CLK);
      #1 s_axi_bready = 1'b0;
   endtask

   // rready stays low for hold cycles while a second read waits
   // and the response must not move
   task automatic axi_read(input logic [7:0] addr, input int hold,
                           output logic [31:0] data, output logic [1:0] resp);
      s_axi_araddr  = addr;
      s_axi_arvalid = 1'b1;
      @(negedge SPI_CLK);
      while (!s_axi_arready) @(negedge SPI_CLK);
      @(posedge SPI_CLK);
      #1 s_axi_arvalid = 1'b0;
      @(negedge SPI_CLK);
      while (!s_axi_rvalid) @(negedge SPI_CLK);
      data = s_axi_rdata;
      resp = s_axi_rresp;
      for (int n = 0; n < hold; n++) begin
         @(posedge SPI_CLK);
         #1;
         s_axi_araddr  = addr ^ 8'h04;
         s_axi_arvalid = 1'b1;
         @(negedge SPI_CLK);
         check_value("s_axi_arready", s_axi_arready, 1'b0);
         check_value("s_axi_rvalid held", s_axi_rvalid, 1'b1);
         check_value("s_axi_rdata held", s_axi_rdata, data);
      end
      @(posedge SPI_CLK);
      #1;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b1;
      @(posedge SPI_CLK);
      #1 s_axi_rready = 1'b0;
   endtask

   task automatic run_row(input logic [31:0] row);
      logic [7:0]  op;
      logic [7:0]  ch;
      logic [7:0]  arg;
      logic [7:0]  exp;
      logic [7:0]  value;
      logic [31:0] rdata;
      logic [1:0]  resp;
      op  = row[31:24];
      ch  = row[23:16];
      arg = row[15:8];
      exp = row[7:0];
      case (op)
         OP_FLUSH: begin
            spi_frame(CMD_FLUSH, 0);
            for (int c = 0; c < NCH; c++) begin
               rx_q[c].delete();
               tx_q[c].delete();
            end
         end
         OP_BUTSW: begin
            mosi_buf[0] = arg;
            spi_frame(CMD_BUT_SW, 1);
            check_value("buttons", buttons, arg[1:0]);
            check_value("switches", switches, arg[3:2]);
         end
         OP_SPI_WR: begin
            for (int i = 0; i < arg; i++) begin
               random_byte(mosi_buf[i]);
               // a full queue drops the byte
               if (rx_q[ch].size() < DEPTH) begin
                  rx_q[ch].push_back(mosi_buf[i]);
               end
            end
            spi_frame((ch == 0) ? CMD_KBD_WR : CMD_SER_WR, arg);
         end
         OP_SPI_RD: begin
            foreach (mosi_buf[i]) mosi_buf[i] = 8'h00;
            spi_frame((ch == 0) ? CMD_KBD_RD : CMD_SER_RD, 2 * arg);
            // reply alternates available byte and data byte
            for (int p = 0; p < arg; p++) begin
               value = (tx_q[ch].size() > 0) ? 8'hFF : 8'h00;
               check_value("spi_miso available byte", miso_buf[1 + 2 * p], value);
               if (tx_q[ch].size() > 0) begin
                  value = tx_q[ch].pop_front();
                  check_value("spi_miso data byte", miso_buf[2 + 2 * p], value);
               end
            end
         end
         OP_AXI_WR: begin
            for (int i = 0; i < arg; i++) begin
               random_byte(value);
               axi_write({ch[4:0], REG_DATA}, {24'h0, value}, resp);
               check_value("s_axi_bresp", resp, AXI_OKAY);
               if (tx_q[ch].size() < DEPTH) begin
                  tx_q[ch].push_back(value);
               end
            end
         end
         OP_AXI_RD: begin
            for (int i = 0; i < arg; i++) begin
               axi_read({ch[4:0], REG_DATA}, 0, rdata, resp);
               value = 8'h00;
               if (rx_q[ch].size() > 0) begin
                  value = rx_q[ch].pop_front();
               end
               check_value("s_axi_rresp", resp, AXI_OKAY);
               check_value("s_axi_rdata", rdata, {24'h0, value});
            end
         end
         OP_STATUS: begin
            axi_read({ch[4:0], REG_STATUS}, arg, rdata, resp);
            check_value("s_axi_rresp", resp, AXI_OKAY);
            check_value("status word", rdata, {24'h0, exp});
         end
         OP_BAD_WR: begin
            axi_write(arg, 32'h0000_005A, resp);
            check_value("s_axi_bresp", resp, AXI_SLVERR);
         end
         OP_BAD_RD: begin
            axi_read(arg, 3, rdata, resp);
            check_value("s_axi_rresp", resp, AXI_SLVERR);
            check_value("s_axi_rdata", rdata, 32'h0);
         end
         default: begin
            errors++;
            $display("stimulus row holds an unknown operation code %0d", op);
         end
      endcase
   endtask

   initial begin
      SPI_SS_IO     = 1'b1;
      spi_mosi      = 1'b0;
      s_axi_awaddr  = 8'h00;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = 32'h0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b0;
      s_axi_araddr  = 8'h00;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      repeat (5) @(posedge SPI_CLK);
      #1 SPI_SS_IO = 1'b0;
      check_value("s_axi_bvalid", s_axi_bvalid, 1'b0);
      check_value("s_axi_rvalid", s_axi_rvalid, 1'b0);
      check_value("s_axi_awready", s_axi_awready, 1'b0);
      check_value("s_axi_arready", s_axi_arready, 1'b0);
      for (int r = 0; r < NROWS; r++) begin
         run_row(STIM[r]);
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire
